//--- cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	// ALU format for register-register ops and shifts
	typedef struct packed {
		logic [1:0] op;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [3:0] op3;
		logic [3:0] d4; // Shift amount
	} alu_fmt_t;

	// Displacement format for LD, ST, LI and branches
	typedef struct packed {
		logic [1:0] op;
		logic [2:0] ra; // Branch class for op 2
		logic [2:0] rb; // Condition for conditional branches
		logic [7:0] d;
	} disp_fmt_t;

	typedef union packed {
		alu_fmt_t  alu;
		disp_fmt_t disp;
	} instr_word_t;

	// Major opcodes
	localparam logic [1:0] OP_LD   = 2'd0;
	localparam logic [1:0] OP_ST   = 2'd1;
	localparam logic [1:0] OP_MISC = 2'd2;
	localparam logic [1:0] OP_ALU  = 2'd3;

	localparam int CMD_W = 5;

	// ALU commands share their op3 code
	localparam logic [CMD_W-1:0] CMD_ADD = 5'd0;
	localparam logic [CMD_W-1:0] CMD_SUB = 5'd1;
	localparam logic [CMD_W-1:0] CMD_AND = 5'd2;
	localparam logic [CMD_W-1:0] CMD_OR  = 5'd3;
	localparam logic [CMD_W-1:0] CMD_XOR = 5'd4;
	localparam logic [CMD_W-1:0] CMD_CMP = 5'd5;
	localparam logic [CMD_W-1:0] CMD_MOV = 5'd6;
	localparam logic [CMD_W-1:0] CMD_SLL = 5'd8;
	localparam logic [CMD_W-1:0] CMD_SLR = 5'd9;
	localparam logic [CMD_W-1:0] CMD_SRL = 5'd10;
	localparam logic [CMD_W-1:0] CMD_SRA = 5'd11;
	localparam logic [CMD_W-1:0] CMD_HLT = 5'd15;
	localparam logic [CMD_W-1:0] CMD_LD  = 5'd16;
	localparam logic [CMD_W-1:0] CMD_ST  = 5'd17;
	localparam logic [CMD_W-1:0] CMD_LI  = 5'd18;
	localparam logic [CMD_W-1:0] CMD_BR  = 5'd19; // Taken branch of any kind
	localparam logic [CMD_W-1:0] CMD_NOP = 5'd31;

	localparam logic [2:0] BR_CLASS_LI   = 3'd0;
	localparam logic [2:0] BR_CLASS_B    = 3'd4;
	localparam logic [2:0] BR_CLASS_COND = 3'd7;

	localparam logic [2:0] COND_BE  = 3'd0;
	localparam logic [2:0] COND_BLT = 3'd1;
	localparam logic [2:0] COND_BLE = 3'd2;
	localparam logic [2:0] COND_BNE = 3'd3;

	localparam int PHASE_W = 3;

	localparam logic [PHASE_W-1:0] PH_IDLE   = 3'd0;
	localparam logic [PHASE_W-1:0] PH_MEMRD  = 3'd1;
	localparam logic [PHASE_W-1:0] PH_FETCH  = 3'd2;
	localparam logic [PHASE_W-1:0] PH_DECODE = 3'd3;
	localparam logic [PHASE_W-1:0] PH_EXEC   = 3'd4;
	localparam logic [PHASE_W-1:0] PH_MEM    = 3'd5;
	localparam logic [PHASE_W-1:0] PH_WB     = 3'd6;

	localparam int CTRL_W = 15;

	// Bit positions in the control word
	localparam int CB_ALUC_E = 0;
	localparam int CB_AR_E   = 1;
	localparam int CB_BR_E   = 2;
	localparam int CB_DR_E   = 3;
	localparam int CB_MDR_E  = 4;
	localparam int CB_IR_E   = 5;
	localparam int CB_REG_E  = 6;
	localparam int CB_GENR_W = 7;
	localparam int CB_PC_E   = 8;
	localparam int CB_MEM_E  = 9;
	localparam int CB_MEM_W  = 10;
	localparam int CB_M2_S   = 11;
	localparam int CB_M3_S   = 12;
	localparam int CB_M5_S   = 13;
	localparam int CB_M6_S   = 14;

endpackage

//--- phase_sequencer.sv
`timescale 1ns/100ps

module phase_sequencer (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            exec,
	input  logic                            halt,
	output logic [cpu_ctrl_pkg::PHASE_W-1:0] phase,
	output logic                            running
);

	logic stop_req; // Stop after the current instruction

	always_ff @(posedge clk) begin
		if (rst) begin
			phase    <= cpu_ctrl_pkg::PH_IDLE;
			running  <= 1'b0;
			stop_req <= 1'b0;
		end else begin
			case (phase)
				cpu_ctrl_pkg::PH_IDLE: begin
					if (!running && exec) begin // Start
						phase   <= cpu_ctrl_pkg::PH_MEMRD;
						running <= 1'b1;
					end else if (running && !exec) begin // Continue
						phase <= cpu_ctrl_pkg::PH_MEMRD;
					end
				end
				cpu_ctrl_pkg::PH_WB: phase <= cpu_ctrl_pkg::PH_IDLE;
				default: phase <= phase + 1'b1;
			endcase

			// A request taken at the WB edge itself waits for the next instruction
			if (phase == cpu_ctrl_pkg::PH_WB && stop_req) begin
				running  <= 1'b0;
				stop_req <= 1'b0;
			end else if ((exec && running) ||
					(halt && phase >= cpu_ctrl_pkg::PH_DECODE)) begin
				stop_req <= 1'b1;
			end
		end
	end

endmodule

//--- instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
	input  logic                            clk,
	input  logic                            rst,
	input  cpu_ctrl_pkg::instr_word_t       instruction,
	input  logic                            s,
	input  logic                            z,
	input  logic                            v,
	input  logic [cpu_ctrl_pkg::PHASE_W-1:0] phase,
	output logic [cpu_ctrl_pkg::CMD_W-1:0]   command,
	output logic                            halt,
	output logic [5:0]                      alu_instruction
);

	logic                          cond_true;
	logic [cpu_ctrl_pkg::CMD_W-1:0] next_cmd;

	always_comb begin
		case (instruction.disp.rb)
			cpu_ctrl_pkg::COND_BE:  cond_true = z;
			cpu_ctrl_pkg::COND_BLT: cond_true = s ^ v;
			cpu_ctrl_pkg::COND_BLE: cond_true = z | (s ^ v);
			cpu_ctrl_pkg::COND_BNE: cond_true = !z;
			default:                cond_true = 1'b0;
		endcase
	end

	always_comb begin
		next_cmd = cpu_ctrl_pkg::CMD_NOP;
		case (instruction.alu.op)
			cpu_ctrl_pkg::OP_ALU: begin
				case (instruction.alu.op3)
					4'd7, 4'd12, 4'd13, 4'd14: next_cmd = cpu_ctrl_pkg::CMD_NOP; // Unused codes and old IN and OUT
					default: next_cmd = {1'b0, instruction.alu.op3};
				endcase
			end
			cpu_ctrl_pkg::OP_LD: next_cmd = cpu_ctrl_pkg::CMD_LD;
			cpu_ctrl_pkg::OP_ST: next_cmd = cpu_ctrl_pkg::CMD_ST;
			cpu_ctrl_pkg::OP_MISC: begin
				case (instruction.disp.ra)
					cpu_ctrl_pkg::BR_CLASS_LI: next_cmd = cpu_ctrl_pkg::CMD_LI;
					cpu_ctrl_pkg::BR_CLASS_B:  next_cmd = cpu_ctrl_pkg::CMD_BR;
					cpu_ctrl_pkg::BR_CLASS_COND: begin
						if (cond_true)
							next_cmd = cpu_ctrl_pkg::CMD_BR;
						else
							next_cmd = cpu_ctrl_pkg::CMD_NOP; // Branch not taken
					end
					default: next_cmd = cpu_ctrl_pkg::CMD_NOP;
				endcase
			end
			default: next_cmd = cpu_ctrl_pkg::CMD_NOP;
		endcase
	end

	// Instruction and flags settle during FETCH
	always_ff @(posedge clk) begin
		if (rst)
			command <= cpu_ctrl_pkg::CMD_NOP;
		else if (phase == cpu_ctrl_pkg::PH_FETCH)
			command <= next_cmd;
	end

	assign halt = (command == cpu_ctrl_pkg::CMD_HLT);

	// Non-ALU formats pass the top six bits of the word
	assign alu_instruction = (instruction.alu.op == cpu_ctrl_pkg::OP_ALU) ?
		{instruction.alu.op, instruction.alu.op3} :
		{instruction.disp.op, instruction.disp.ra, instruction.disp.rb[2]};

endmodule

//--- control_word_gen.sv
`timescale 1ns/100ps

module control_word_gen (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [cpu_ctrl_pkg::PHASE_W-1:0] phase,
	input  logic [cpu_ctrl_pkg::CMD_W-1:0]   command,
	output logic [cpu_ctrl_pkg::CTRL_W-1:0]  ctrl
);

	logic [cpu_ctrl_pkg::CTRL_W-1:0] word; // Entry for the current phase and command

	always_comb begin
		word = '0;
		case (phase)
			cpu_ctrl_pkg::PH_MEMRD: word[cpu_ctrl_pkg::CB_MEM_E] = 1'b1;
			cpu_ctrl_pkg::PH_FETCH: begin
				word[cpu_ctrl_pkg::CB_REG_E] = 1'b1;
				word[cpu_ctrl_pkg::CB_PC_E]  = 1'b1; // PC+1
				word[cpu_ctrl_pkg::CB_MEM_E] = 1'b1;
			end
			cpu_ctrl_pkg::PH_DECODE: begin
				case (command)
					cpu_ctrl_pkg::CMD_ADD, cpu_ctrl_pkg::CMD_SUB, cpu_ctrl_pkg::CMD_AND,
					cpu_ctrl_pkg::CMD_OR, cpu_ctrl_pkg::CMD_XOR, cpu_ctrl_pkg::CMD_CMP,
					cpu_ctrl_pkg::CMD_MOV, cpu_ctrl_pkg::CMD_LD, cpu_ctrl_pkg::CMD_ST: begin
						word[cpu_ctrl_pkg::CB_IR_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E] = 1'b1;
					end
					cpu_ctrl_pkg::CMD_SLL, cpu_ctrl_pkg::CMD_SLR, cpu_ctrl_pkg::CMD_SRL,
					cpu_ctrl_pkg::CMD_SRA, cpu_ctrl_pkg::CMD_LI: begin
						word[cpu_ctrl_pkg::CB_IR_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_M2_S]  = 1'b1; // Immediate d
					end
					cpu_ctrl_pkg::CMD_BR: begin
						word[cpu_ctrl_pkg::CB_IR_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_PC_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_M2_S]  = 1'b1;
						word[cpu_ctrl_pkg::CB_M3_S]  = 1'b1; // PC+1 as operand
					end
					cpu_ctrl_pkg::CMD_HLT: begin
						word[cpu_ctrl_pkg::CB_AR_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_BR_E] = 1'b1;
					end
					default: word = '0;
				endcase
			end
			cpu_ctrl_pkg::PH_EXEC: begin
				case (command)
					cpu_ctrl_pkg::CMD_ADD, cpu_ctrl_pkg::CMD_SUB, cpu_ctrl_pkg::CMD_AND,
					cpu_ctrl_pkg::CMD_OR, cpu_ctrl_pkg::CMD_XOR, cpu_ctrl_pkg::CMD_CMP,
					cpu_ctrl_pkg::CMD_SLL, cpu_ctrl_pkg::CMD_SLR, cpu_ctrl_pkg::CMD_SRL,
					cpu_ctrl_pkg::CMD_SRA: begin
						word[cpu_ctrl_pkg::CB_ALUC_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_AR_E]   = 1'b1;
						word[cpu_ctrl_pkg::CB_BR_E]   = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E]  = 1'b1;
					end
					cpu_ctrl_pkg::CMD_MOV: begin
						word[cpu_ctrl_pkg::CB_ALUC_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_AR_E]   = 1'b1; // Only Ra is needed
						word[cpu_ctrl_pkg::CB_REG_E]  = 1'b1;
					end
					cpu_ctrl_pkg::CMD_LD, cpu_ctrl_pkg::CMD_ST: begin
						word[cpu_ctrl_pkg::CB_ALUC_E] = 1'b1; // Address Rb + d
						word[cpu_ctrl_pkg::CB_AR_E]   = (command == cpu_ctrl_pkg::CMD_ST);
						word[cpu_ctrl_pkg::CB_BR_E]   = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_M2_S]   = 1'b1;
					end
					cpu_ctrl_pkg::CMD_LI: word[cpu_ctrl_pkg::CB_ALUC_E] = 1'b1;
					cpu_ctrl_pkg::CMD_BR: begin
						word[cpu_ctrl_pkg::CB_ALUC_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E]  = 1'b1;
					end
					cpu_ctrl_pkg::CMD_HLT: begin
						word[cpu_ctrl_pkg::CB_AR_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_BR_E] = 1'b1;
					end
					default: word = '0;
				endcase
			end
			cpu_ctrl_pkg::PH_MEM: begin
				case (command)
					cpu_ctrl_pkg::CMD_LD, cpu_ctrl_pkg::CMD_ST: begin
						word[cpu_ctrl_pkg::CB_DR_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_MDR_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_IR_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_MEM_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_M6_S]  = 1'b1; // DR as memory address
					end
					cpu_ctrl_pkg::CMD_HLT: begin
						word[cpu_ctrl_pkg::CB_AR_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_BR_E] = 1'b1;
					end
					default: word = '0;
				endcase
			end
			cpu_ctrl_pkg::PH_WB: begin
				case (command)
					cpu_ctrl_pkg::CMD_ADD, cpu_ctrl_pkg::CMD_SUB, cpu_ctrl_pkg::CMD_AND,
					cpu_ctrl_pkg::CMD_OR, cpu_ctrl_pkg::CMD_XOR, cpu_ctrl_pkg::CMD_MOV,
					cpu_ctrl_pkg::CMD_SLL, cpu_ctrl_pkg::CMD_SLR, cpu_ctrl_pkg::CMD_SRL,
					cpu_ctrl_pkg::CMD_SRA: begin
						word[cpu_ctrl_pkg::CB_DR_E]   = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_GENR_W] = 1'b1;
						word[cpu_ctrl_pkg::CB_M5_S]   = 1'b1;
					end
					cpu_ctrl_pkg::CMD_LD, cpu_ctrl_pkg::CMD_ST: begin
						word[cpu_ctrl_pkg::CB_DR_E]   = 1'b1;
						word[cpu_ctrl_pkg::CB_REG_E]  = 1'b1;
						word[cpu_ctrl_pkg::CB_GENR_W] = (command == cpu_ctrl_pkg::CMD_LD);
						word[cpu_ctrl_pkg::CB_MEM_E]  = (command == cpu_ctrl_pkg::CMD_LD);
						word[cpu_ctrl_pkg::CB_MEM_W]  = (command == cpu_ctrl_pkg::CMD_ST);
						word[cpu_ctrl_pkg::CB_M6_S]   = 1'b1;
					end
					cpu_ctrl_pkg::CMD_LI: begin
						word[cpu_ctrl_pkg::CB_GENR_W] = 1'b1;
						word[cpu_ctrl_pkg::CB_M5_S]   = 1'b1; // Write into Rb
					end
					cpu_ctrl_pkg::CMD_BR: begin
						word[cpu_ctrl_pkg::CB_DR_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_PC_E] = 1'b1; // Load branch target
					end
					cpu_ctrl_pkg::CMD_HLT: begin
						word[cpu_ctrl_pkg::CB_AR_E] = 1'b1;
						word[cpu_ctrl_pkg::CB_BR_E] = 1'b1;
					end
					default: word = '0; // CMP writes nothing back
				endcase
			end
			default: word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			ctrl <= '0;
		else
			ctrl <= word;
	end

endmodule

//--- control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input  logic        clk,
	input  logic        rst,
	input  logic        exec,
	input  logic [15:0] instruction,
	input  logic        s,
	input  logic        z,
	input  logic        v,
	output logic        aluc_e,
	output logic        ar_e,
	output logic        br_e,
	output logic        dr_e,
	output logic        mdr_e,
	output logic        ir_e,
	output logic        reg_e,
	output logic        genr_w,
	output logic        pc_e,
	output logic        mem_e,
	output logic        mem_w,
	output logic        m2_s,
	output logic        m3_s,
	output logic        m5_s,
	output logic        m6_s,
	output logic [5:0]  alu_instruction,
	output logic        running
);

	logic [cpu_ctrl_pkg::PHASE_W-1:0] phase;
	logic [cpu_ctrl_pkg::CMD_W-1:0]   command;
	logic                            halt;
	logic [cpu_ctrl_pkg::CTRL_W-1:0]  ctrl;

	phase_sequencer u_seq (
		.clk     (clk),
		.rst     (rst),
		.exec    (exec),
		.halt    (halt),
		.phase   (phase),
		.running (running)
	);

	instr_decoder u_dec (
		.clk             (clk),
		.rst             (rst),
		.instruction     (instruction), // Raw word seen through the union
		.s               (s),
		.z               (z),
		.v               (v),
		.phase           (phase),
		.command         (command),
		.halt            (halt),
		.alu_instruction (alu_instruction)
	);

	control_word_gen u_cwg (
		.clk     (clk),
		.rst     (rst),
		.phase   (phase),
		.command (command),
		.ctrl    (ctrl)
	);

	assign aluc_e = ctrl[cpu_ctrl_pkg::CB_ALUC_E];
	assign ar_e   = ctrl[cpu_ctrl_pkg::CB_AR_E];
	assign br_e   = ctrl[cpu_ctrl_pkg::CB_BR_E];
	assign dr_e   = ctrl[cpu_ctrl_pkg::CB_DR_E];
	assign mdr_e  = ctrl[cpu_ctrl_pkg::CB_MDR_E];
	assign ir_e   = ctrl[cpu_ctrl_pkg::CB_IR_E];
	assign reg_e  = ctrl[cpu_ctrl_pkg::CB_REG_E];
	assign genr_w = ctrl[cpu_ctrl_pkg::CB_GENR_W];
	assign pc_e   = ctrl[cpu_ctrl_pkg::CB_PC_E];
	assign mem_e  = ctrl[cpu_ctrl_pkg::CB_MEM_E];
	assign mem_w  = ctrl[cpu_ctrl_pkg::CB_MEM_W];
	assign m2_s   = ctrl[cpu_ctrl_pkg::CB_M2_S];
	assign m3_s   = ctrl[cpu_ctrl_pkg::CB_M3_S];
	assign m5_s   = ctrl[cpu_ctrl_pkg::CB_M5_S];
	assign m6_s   = ctrl[cpu_ctrl_pkg::CB_M6_S];

endmodule

//--- control_unit_assertions.sv
`timescale 1ns/100ps

module control_unit_assertions (
	input logic clk,
	input logic rst,
	input logic exec,
	input logic running,
	input logic aluc_e,
	input logic ar_e,
	input logic br_e,
	input logic dr_e,
	input logic mdr_e,
	input logic ir_e,
	input logic reg_e,
	input logic genr_w,
	input logic pc_e,
	input logic mem_e,
	input logic mem_w,
	input logic m2_s,
	input logic m3_s,
	input logic m5_s,
	input logic m6_s
);

	logic any_strobe;

	assign any_strobe = aluc_e | ar_e | br_e | dr_e | mdr_e | ir_e | reg_e | genr_w |
		pc_e | mem_e | mem_w | m2_s | m3_s | m5_s | m6_s;

	// Register file write and memory write use the same bus cycle
	write_exclusive: assert property (@(posedge clk) disable iff (rst) !(genr_w && mem_w))
		else $error("genr_w and mem_w high in the same cycle");

	single_mem_write: assert property (@(posedge clk) disable iff (rst) mem_w |=> !mem_w)
		else $error("mem_w high for two cycles");

	quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !any_strobe)
		else $error("strobe active in the first cycle after reset");

	start_needs_exec: assert property (@(posedge clk) disable iff (rst)
		$rose(running) |-> $past(exec))
		else $error("running rose without exec");

endmodule

bind control_unit control_unit_assertions u_assertions (.*);

//--- control_unit_tb.sv
`timescale 1ns/100ps

module control_unit_tb;

	typedef logic [cpu_ctrl_pkg::CTRL_W-1:0] ctrl_word_t;

	// One mask per strobe
	localparam ctrl_word_t ALUC_E = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_ALUC_E;
	localparam ctrl_word_t AR_E   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_AR_E;
	localparam ctrl_word_t BR_E   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_BR_E;
	localparam ctrl_word_t DR_E   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_DR_E;
	localparam ctrl_word_t MDR_E  = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_MDR_E;
	localparam ctrl_word_t IR_E   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_IR_E;
	localparam ctrl_word_t REG_E  = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_REG_E;
	localparam ctrl_word_t GENR_W = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_GENR_W;
	localparam ctrl_word_t PC_E   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_PC_E;
	localparam ctrl_word_t MEM_E  = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_MEM_E;
	localparam ctrl_word_t MEM_W  = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_MEM_W;
	localparam ctrl_word_t M2_S   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_M2_S;
	localparam ctrl_word_t M3_S   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_M3_S;
	localparam ctrl_word_t M5_S   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_M5_S;
	localparam ctrl_word_t M6_S   = ctrl_word_t'(1) << cpu_ctrl_pkg::CB_M6_S;

	// Rows of the strobe table
	localparam int KIND_ALU   = 0; // ADD SUB AND OR XOR
	localparam int KIND_CMP   = 1;
	localparam int KIND_MOV   = 2;
	localparam int KIND_SHIFT = 3;
	localparam int KIND_LD    = 4;
	localparam int KIND_ST    = 5;
	localparam int KIND_LI    = 6;
	localparam int KIND_BR    = 7;
	localparam int KIND_HLT   = 8;
	localparam int KIND_NOP   = 9;

	logic        clk;
	logic        rst;
	logic        exec;
	logic [15:0] instruction;
	logic        s;
	logic        z;
	logic        v;
	logic        aluc_e, ar_e, br_e, dr_e, mdr_e;
	logic        ir_e, reg_e, genr_w, pc_e, mem_e;
	logic        mem_w, m2_s, m3_s, m5_s, m6_s;
	logic [5:0]  alu_instruction;
	logic        running;
	ctrl_word_t  observed;
	logic [15:0] lfsr;
	int          word_errors;
	int          alu_errors;
	int          running_errors;
	int          timeouts;

	control_unit dut (.*);

	always #2 clk = ~clk;

	always_comb begin
		observed[cpu_ctrl_pkg::CB_ALUC_E] = aluc_e;
		observed[cpu_ctrl_pkg::CB_AR_E]   = ar_e;
		observed[cpu_ctrl_pkg::CB_BR_E]   = br_e;
		observed[cpu_ctrl_pkg::CB_DR_E]   = dr_e;
		observed[cpu_ctrl_pkg::CB_MDR_E]  = mdr_e;
		observed[cpu_ctrl_pkg::CB_IR_E]   = ir_e;
		observed[cpu_ctrl_pkg::CB_REG_E]  = reg_e;
		observed[cpu_ctrl_pkg::CB_GENR_W] = genr_w;
		observed[cpu_ctrl_pkg::CB_PC_E]   = pc_e;
		observed[cpu_ctrl_pkg::CB_MEM_E]  = mem_e;
		observed[cpu_ctrl_pkg::CB_MEM_W]  = mem_w;
		observed[cpu_ctrl_pkg::CB_M2_S]   = m2_s;
		observed[cpu_ctrl_pkg::CB_M3_S]   = m3_s;
		observed[cpu_ctrl_pkg::CB_M5_S]   = m5_s;
		observed[cpu_ctrl_pkg::CB_M6_S]   = m6_s;
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[14:0], next_random_bit()};
		return r;
	endfunction

	function automatic logic [2:0] rand_flags(); // {s, z, v}
		return 3'(random_bits(3));
	endfunction

	function automatic cpu_ctrl_pkg::instr_word_t alu_word(input logic [4:0] cmd);
		cpu_ctrl_pkg::instr_word_t w;
		w = random_bits(16);
		w.alu.op  = cpu_ctrl_pkg::OP_ALU;
		w.alu.op3 = cmd[3:0];
		return w;
	endfunction

	function automatic cpu_ctrl_pkg::instr_word_t mem_word(input logic [1:0] op);
		cpu_ctrl_pkg::instr_word_t w;
		w = random_bits(16);
		w.disp.op = op;
		return w;
	endfunction

	function automatic cpu_ctrl_pkg::instr_word_t misc_word(input logic [2:0] cls,
			input logic [2:0] cond);
		cpu_ctrl_pkg::instr_word_t w;
		w = random_bits(16);
		w.disp.op = cpu_ctrl_pkg::OP_MISC;
		w.disp.ra = cls;
		w.disp.rb = cond;
		return w;
	endfunction

	function automatic logic branch_taken(input logic [2:0] cond, input logic [2:0] f);
		case (cond)
			3'd0: return f[1]; // BE
			3'd1: return f[2] != f[0]; // BLT
			3'd2: return f[1] || (f[2] != f[0]);
			3'd3: return !f[1];
			default: return 1'b0;
		endcase
	endfunction

	function automatic ctrl_word_t expected_word(input int ph, input int kind);
		ctrl_word_t w;
		w = '0;
		case (ph)
			1: w = MEM_E;
			2: w = REG_E | PC_E | MEM_E;
			3: begin
				case (kind)
					KIND_ALU, KIND_CMP, KIND_MOV, KIND_LD, KIND_ST: w = IR_E | REG_E;
					KIND_SHIFT, KIND_LI: w = IR_E | REG_E | M2_S;
					KIND_BR: w = IR_E | REG_E | PC_E | M2_S | M3_S;
					KIND_HLT: w = AR_E | BR_E;
					default: w = '0;
				endcase
			end
			4: begin
				case (kind)
					KIND_ALU, KIND_CMP, KIND_SHIFT: w = ALUC_E | AR_E | BR_E | REG_E;
					KIND_MOV: w = ALUC_E | AR_E | REG_E;
					KIND_LD: w = ALUC_E | BR_E | REG_E | M2_S;
					KIND_ST: w = ALUC_E | AR_E | BR_E | REG_E | M2_S;
					KIND_LI: w = ALUC_E;
					KIND_BR: w = ALUC_E | REG_E;
					KIND_HLT: w = AR_E | BR_E;
					default: w = '0;
				endcase
			end
			5: begin
				case (kind)
					KIND_LD, KIND_ST: w = DR_E | MDR_E | IR_E | REG_E | MEM_E | M6_S;
					KIND_HLT: w = AR_E | BR_E;
					default: w = '0;
				endcase
			end
			6: begin
				case (kind)
					KIND_ALU, KIND_MOV, KIND_SHIFT: w = DR_E | REG_E | GENR_W | M5_S;
					KIND_LD: w = DR_E | REG_E | GENR_W | MEM_E | M6_S;
					KIND_ST: w = DR_E | REG_E | MEM_W | M6_S;
					KIND_LI: w = GENR_W | M5_S;
					KIND_BR: w = DR_E | PC_E;
					KIND_HLT: w = AR_E | BR_E;
					default: w = '0; // CMP and NOP
				endcase
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	task automatic check_word(input ctrl_word_t got, input ctrl_word_t exp, input string what);
		if (got !== exp) begin
			word_errors++;
			$display("FAILED %0t ns: control word %b, expected %b (%s)", $time, got, exp, what);
		end
	endtask

	task automatic check_alu_instr(input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp) begin
			alu_errors++;
			$display("FAILED %0t ns: alu_instruction %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_running(input logic got, input logic exp);
		if (got !== exp) begin
			running_errors++;
			$display("FAILED %0t ns: running %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic wait_running(input logic level, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (running !== level && n < limit);
		if (running !== level) begin
			timeouts++;
			$display("Timeout at %0t ns: running never changed to %b", $time, level);
		end
	endtask

	// Runs one instruction from its start or continue edge through WB
	task automatic run_instr(input cpu_ctrl_pkg::instr_word_t word, input logic [2:0] flags,
			input int kind, input logic start, input logic stop);
		logic [5:0] exp_alu;
		logic       stops;
		exp_alu = (word.alu.op == cpu_ctrl_pkg::OP_ALU) ? {word.alu.op, word.alu.op3} :
			word[15:10];
		stops = stop || (kind == KIND_HLT);
		@(posedge clk);
		instruction <= word;
		s <= flags[2];
		z <= flags[1];
		v <= flags[0];
		if (start) begin
			exec <= 1'b1;
			@(posedge clk);
			exec <= 1'b0;
			wait_running(1'b1, 10);
		end else begin
			@(negedge clk);
		end
		for (int ph = 0; ph < 7; ph++) begin
			if (ph > 0) begin
				@(posedge clk);
				exec <= stop && (ph == 3); // Pulse seen at the edge leaving EXEC
				@(negedge clk);
			end
			check_word(observed, expected_word(ph, kind),
				$sformatf("kind %0d phase %0d", kind, ph));
			check_alu_instr(alu_instruction, exp_alu);
			check_running(running, !(stops && ph == 6));
		end
	endtask

	task automatic check_stopped(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_word(observed, '0, "stopped");
			check_running(running, 1'b0);
		end
	endtask

	task automatic idle_after_reset();
		check_stopped(20);
	endtask

	task automatic alu_ops();
		run_instr(alu_word(cpu_ctrl_pkg::CMD_ADD), rand_flags(), KIND_ALU, 1'b1, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_SUB), rand_flags(), KIND_ALU, 1'b0, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_XOR), rand_flags(), KIND_ALU, 1'b0, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_CMP), rand_flags(), KIND_CMP, 1'b0, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_MOV), rand_flags(), KIND_MOV, 1'b0, 1'b1);
		check_stopped(6);
	endtask

	task automatic shifts_and_memory();
		run_instr(alu_word(cpu_ctrl_pkg::CMD_SLL), rand_flags(), KIND_SHIFT, 1'b1, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_SLR), rand_flags(), KIND_SHIFT, 1'b0, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_SRL), rand_flags(), KIND_SHIFT, 1'b0, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_SRA), rand_flags(), KIND_SHIFT, 1'b0, 1'b0);
		run_instr(alu_word(5'd13), rand_flags(), KIND_NOP, 1'b0, 1'b0); // Former OUT code
		run_instr(misc_word(cpu_ctrl_pkg::BR_CLASS_LI, 3'(random_bits(3))), rand_flags(),
			KIND_LI, 1'b0, 1'b0);
		run_instr(mem_word(cpu_ctrl_pkg::OP_LD), rand_flags(), KIND_LD, 1'b0, 1'b0);
		run_instr(mem_word(cpu_ctrl_pkg::OP_ST), rand_flags(), KIND_ST, 1'b0, 1'b1);
		check_stopped(6);
	endtask

	task automatic branches();
		logic [2:0] f;
		int         kind;
		run_instr(misc_word(cpu_ctrl_pkg::BR_CLASS_B, 3'(random_bits(3))), rand_flags(),
			KIND_BR, 1'b1, 1'b0);
		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < 3; k++) begin
				f = rand_flags();
				kind = branch_taken(3'(c), f) ? KIND_BR : KIND_NOP;
				run_instr(misc_word(cpu_ctrl_pkg::BR_CLASS_COND, 3'(c)), f, kind, 1'b0,
					c == 7 && k == 2);
			end
		end
		check_stopped(6);
	endtask

	task automatic run_control();
		run_instr(alu_word(cpu_ctrl_pkg::CMD_ADD), rand_flags(), KIND_ALU, 1'b1, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_SUB), rand_flags(), KIND_ALU, 1'b0, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_AND), rand_flags(), KIND_ALU, 1'b0, 1'b1);
		check_stopped(8);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_OR), rand_flags(), KIND_ALU, 1'b1, 1'b0);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_HLT), rand_flags(), KIND_HLT, 1'b0, 1'b0);
		check_stopped(8);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_HLT), rand_flags(), KIND_HLT, 1'b1, 1'b0);
		check_stopped(8);
		run_instr(alu_word(cpu_ctrl_pkg::CMD_XOR), rand_flags(), KIND_ALU, 1'b1, 1'b1);
		check_stopped(4);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		exec = 1'b0;
		instruction = '0;
		s = 1'b0;
		z = 1'b0;
		v = 1'b0;
		lfsr = 16'd10976;
		word_errors = 0;
		alu_errors = 0;
		running_errors = 0;
		timeouts = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idle_after_reset();
		alu_ops();
		shifts_and_memory();
		branches();
		run_control();
		$display("Errors: control word %0d, alu_instruction %0d, running %0d, timeouts %0d",
			word_errors, alu_errors, running_errors, timeouts);
		if (word_errors + alu_errors + running_errors + timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- tb.f
cpu_ctrl_pkg.sv
phase_sequencer.sv
instr_decoder.sv
control_word_gen.sv
control_unit.sv
control_unit_assertions.sv
control_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module control_unit_tb \
	-f tb.f -o control_unit_sim &&
	./obj_dir/control_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
